/* eth_rx.f */
logic/eth_rx_pkg.sv
logic/crc32_eth.sv
logic/gmii_rx_framer.sv
logic/rx_slot_dispatch.sv
logic/rx_frame_slot.sv
logic/wb_rx_reader.sv
logic/eth_rx_top.sv
tb/tb_clock_gen.sv
tb/eth_rx_asserts.sv
tb/eth_rx_tb.sv

/* Bender.yml */
package:
  name: eth_rx

sources:
  # Receive MAC and frame store
  - logic/eth_rx_pkg.sv
  - logic/crc32_eth.sv
  - logic/gmii_rx_framer.sv
  - logic/rx_slot_dispatch.sv
  - logic/rx_frame_slot.sv
  - logic/wb_rx_reader.sv
  - logic/eth_rx_top.sv

  # Testbench
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/eth_rx_asserts.sv
      - tb/eth_rx_tb.sv

/* tb/eth_rx_tb.sv */
`timescale 1ns/100ps

module eth_rx_tb;

	localparam int num_slots  = 4;
	localparam int slot_words = 64;
	localparam int slot_bytes = slot_words * 4;
	// Idle line after each frame covers commit and the slot update
	localparam int frame_gap  = 12;
	// One frame that does not fit a slot
	localparam int long_len   = slot_bytes + 10;

	logic                     gmii_rx_clk;
	logic                     arst_n;
	logic                     gmii_rx_dv;
	logic                     gmii_rx_er;
	logic [7:0]               gmii_rxd;
	eth_rx_pkg::wb_req_t      wb_req;
	eth_rx_pkg::wb_rsp_t      wb_rsp;

	// Payload of the frame on the wire
	logic [7:0]               pay [long_len];
	// Reference view of every slot and of the lost frame counter
	logic [7:0]               ref_bytes [num_slots][slot_bytes];
	eth_rx_pkg::slot_status_t ref_status [num_slots];
	logic [15:0]              ref_drops;

	// Pending read responses with their kind (0 word, 1 status, 2 counter)
	int                       exp_kind [$];
	logic [31:0]              exp_val [$];

	int                       cycle_count = 0;
	int                       cycle_limit = 0;

	tb_clock_gen #(
		.reset_cycles (16)
	) u_clk (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n)
	);

	eth_rx_top #(
		.NUM_SLOTS  (num_slots),
		.SLOT_WORDS (slot_words)
	) UUT (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.gmii_rx_dv  (gmii_rx_dv),
		.gmii_rx_er  (gmii_rx_er),
		.gmii_rxd    (gmii_rxd),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp)
	);

	bind gmii_rx_framer eth_rx_asserts u_asserts (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.beat        (beat),
		.event_o     (event_o),
		.state       (state)
	);

	//////////////////////////////
	// Failure and compare tasks

	task automatic fail_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_status(input string name, input eth_rx_pkg::slot_status_t got,
			input eth_rx_pkg::slot_status_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	task automatic check_count(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	//////////////////////////////
	// Reference model

	// Reflected 802.3 CRC-32 complemented at the end
	function automatic logic [31:0] crc32_ref(input int n);
		logic [31:0] r;
		r = '1;
		for (int i = 0; i < n; i++) begin
			r = r ^ {24'd0, pay[i]};
			for (int b = 0; b < 8; b++)
				r = r[0] ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
		end
		return ~r;
	endfunction

	// Packed word as the host reads it with the first byte on top and zero fill
	function automatic logic [31:0] ref_word(input int s, input int w);
		logic [31:0] word;
		word = '0;
		for (int k = 0; k < 4; k++) begin
			if (w * 4 + k < ref_status[s].len_bytes)
				word[31 - 8 * k -: 8] = ref_bytes[s][w * 4 + k];
		end
		return word;
	endfunction

	function automatic int lowest_free();
		for (int s = 0; s < num_slots; s++) begin
			if (!ref_status[s].full)
				return s;
		end
		return -1;
	endfunction

	// Where a frame ends up once it has passed the framer
	task automatic ref_frame(input int n, input bit good);
		int s;
		s = lowest_free();
		if (s < 0) begin
			ref_drops = ref_drops + 16'd1;
		end else if (!good) begin
			ref_status[s] = '0;
		end else if (n > slot_bytes) begin
			ref_status[s] = '{full: 1'b0, overflow: 1'b1, len_bytes: 11'(slot_bytes)};
		end else begin
			ref_status[s] = '{full: 1'b1, overflow: 1'b0, len_bytes: 11'(n)};
			for (int i = 0; i < n; i++)
				ref_bytes[s][i] = pay[i];
		end
	endtask

	// Line time of one frame plus its gap
	function automatic int wire_cycles(input int n);
		return n + 14 + frame_gap;
	endfunction

	//////////////////////////////
	// GMII stimulus

	task automatic drive_byte(input logic [7:0] b, input logic er);
		@(posedge gmii_rx_clk);
		#1;
		gmii_rx_dv = 1'b1;
		gmii_rx_er = er;
		gmii_rxd   = b;
	endtask

	task automatic end_frame();
		@(posedge gmii_rx_clk);
		#1;
		gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		gmii_rxd   = 8'h00;
		repeat (frame_gap) @(posedge gmii_rx_clk);
	endtask

	// Frame kind is 0 good, 1 corrupted FCS or 2 er in the payload
	task automatic receive(input int n, input int kind);
		logic [31:0] fcs;
		for (int i = 0; i < n; i++)
			pay[i] = 8'($urandom);
		fcs = crc32_ref(n);
		if (kind == 1)
			fcs[3] = ~fcs[3];
		for (int i = 0; i < 7; i++)
			drive_byte(eth_rx_pkg::preamble_byte, 1'b0);
		drive_byte(eth_rx_pkg::sfd_byte, 1'b0);
		for (int i = 0; i < n; i++)
			drive_byte(pay[i], kind == 2 && i == n / 2);
		// FCS goes out low byte first
		for (int i = 0; i < 4; i++)
			drive_byte(fcs[8 * i +: 8], 1'b0);
		end_frame();
		ref_frame(n, kind == 0);
	endtask

	// Line activity that must never reach a slot
	task automatic send_junk(input int kind);
		case (kind)
			0: begin
				// Wrong first byte
				drive_byte(8'h5a, 1'b0);
				for (int i = 0; i < 6; i++)
					drive_byte(eth_rx_pkg::preamble_byte, 1'b0);
				drive_byte(eth_rx_pkg::sfd_byte, 1'b0);
				for (int i = 0; i < 8; i++)
					drive_byte(8'($urandom), 1'b0);
			end
			1: begin
				// One bad byte inside the preamble
				for (int i = 0; i < 3; i++)
					drive_byte(eth_rx_pkg::preamble_byte, 1'b0);
				drive_byte(8'h57, 1'b0);
				for (int i = 0; i < 3; i++)
					drive_byte(eth_rx_pkg::preamble_byte, 1'b0);
				drive_byte(eth_rx_pkg::sfd_byte, 1'b0);
				for (int i = 0; i < 8; i++)
					drive_byte(8'($urandom), 1'b0);
			end
			default: begin
				// Carrier gone before the SFD
				for (int i = 0; i < 5; i++)
					drive_byte(eth_rx_pkg::preamble_byte, 1'b0);
			end
		endcase
		end_frame();
	endtask

	//////////////////////////////
	// Wishbone master

	// One classic cycle held until ack
	task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat);
		@(posedge gmii_rx_clk);
		#1;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		@(negedge gmii_rx_clk);
		while (!wb_rsp.ack)
			@(negedge gmii_rx_clk);
		@(posedge gmii_rx_clk);
		#1;
		wb_req = '0;
	endtask

	task automatic read_status(input int s);
		exp_kind.push_back(1);
		exp_val.push_back({19'd0, ref_status[s]});
		wb_cycle(1'b0, {2'b01, 6'(s)}, 32'd0);
	endtask

	task automatic read_drops();
		exp_kind.push_back(2);
		exp_val.push_back({16'd0, ref_drops});
		wb_cycle(1'b0, 8'h80, 32'd0);
	endtask

	// Status goes first as it selects the slot for the data words
	task automatic read_slot(input int s);
		int words;
		read_status(s);
		words = (ref_status[s].len_bytes + 3) / 4;
		for (int w = 0; w < words; w++) begin
			exp_kind.push_back(0);
			exp_val.push_back(ref_word(s, w));
			wb_cycle(1'b0, {2'b00, 6'(w)}, 32'd0);
		end
	endtask

	task automatic release_slot(input int s);
		wb_cycle(1'b1, {2'b01, 6'(s)}, 32'd0);
		if (ref_status[s].full)
			ref_status[s] = '0;
	endtask

	task automatic check_all_slots();
		for (int s = 0; s < num_slots; s++)
			read_status(s);
		read_drops();
	endtask

	//////////////////////////////
	// Response compare

	always @(negedge gmii_rx_clk) begin : compare_rsp
		int          kind;
		logic [31:0] val;
		if (arst_n && wb_rsp.ack && !wb_req.we) begin
			if (exp_kind.size() == 0) begin
				$display("Read acknowledged while no response was expected");
				fail_run();
			end else begin
				kind = exp_kind.pop_front();
				val  = exp_val.pop_front();
				case (kind)
					0: check_word("wb_rsp.dat (frame word)", wb_rsp.dat, val);
					1: check_status("wb_rsp.dat (slot status)",
						eth_rx_pkg::slot_status_t'(wb_rsp.dat[12:0]),
						eth_rx_pkg::slot_status_t'(val[12:0]));
					default: check_count("wb_rsp.dat (drop counter)", wb_rsp.dat[15:0],
						val[15:0]);
				endcase
			end
		end
	end

	// Watchdog
	always @(posedge gmii_rx_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			fail_run();
		end
	end

	//////////////////////////////
	// Test sequence

	initial begin
		gmii_rx_dv = 1'b0;
		gmii_rx_er = 1'b0;
		gmii_rxd   = 8'h00;
		wb_req     = '0;
		ref_drops  = '0;
		for (int s = 0; s < num_slots; s++)
			ref_status[s] = '0;
		void'($urandom(32'h1d616012));

		// Every frame below plus reset and margin for the host reads
		cycle_limit = 16 + 2000 + 3 * wire_cycles(16);
		for (int i = 0; i < num_slots; i++)
			cycle_limit += wire_cycles(45 + i % 4);
		cycle_limit += wire_cycles(20) + wire_cycles(30) + wire_cycles(40);
		cycle_limit += wire_cycles(33) + wire_cycles(long_len) + wire_cycles(12);

		wait (arst_n === 1'b1);
		check_all_slots();

		// Fill every slot with 1 to 4 bytes in the last word
		for (int i = 0; i < num_slots; i++) begin
			receive(45 + i % 4, 0);
			check_all_slots();
		end
		for (int s = 0; s < num_slots; s++)
			read_slot(s);

		// Preamble trouble while every slot is full would show a false start in the counter
		for (int k = 0; k < 3; k++)
			send_junk(k);
		check_all_slots();

		// With no room left the frame is counted as lost
		receive(20, 0);
		check_all_slots();

		// Freed slot takes the next frame
		release_slot(1);
		check_all_slots();
		receive(30, 0);
		read_slot(1);
		check_all_slots();

		// Bad frames leave everything free
		for (int s = 0; s < num_slots; s++)
			release_slot(s);
		receive(40, 1);
		check_all_slots();
		receive(33, 2);
		check_all_slots();

		// Oversized frame is thrown away and the slot stays usable
		receive(long_len, 0);
		check_all_slots();
		receive(12, 0);
		read_slot(0);
		check_all_slots();

		repeat (4) @(posedge gmii_rx_clk);
		if (exp_kind.size() != 0)
			$display("%0d read responses never arrived", exp_kind.size());
		if (UUT.u_framer.u_asserts.fail_count != 0)
			$display("Framer assertions failed %0d times", UUT.u_framer.u_asserts.fail_count);
		if (exp_kind.size() == 0 && UUT.u_framer.u_asserts.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule

/* tb/eth_rx_asserts.sv */
`timescale 1ns/100ps

module eth_rx_asserts (
	input logic                  gmii_rx_clk,
	input logic                  arst_n,
	input eth_rx_pkg::rx_beat_t  beat,
	input eth_rx_pkg::rx_event_t event_o,
	input logic [2:0]            state
);

	// Idle is the first state of the framer FSM
	localparam logic [2:0] idle_code = 3'd0;

	// Failures seen so far, read by the testbench at the end
	int fail_count = 0;

	//////////////////////////////
	// Framer output rules

	// A frame start never carries data
	start_not_with_beat: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		!(event_o.start && beat.valid))
	else begin
		$error("start and a data beat in the same cycle");
		fail_count++;
	end

	// A frame ends one way only
	commit_not_with_drop: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		!(event_o.commit && event_o.drop))
	else begin
		$error("commit and drop together");
		fail_count++;
	end

	// End markers come after the last beat
	end_not_with_beat: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		!((event_o.commit || event_o.drop) && beat.valid))
	else begin
		$error("frame end marker in a beat cycle");
		fail_count++;
	end

	// Nothing leaves the framer between frames
	no_beat_in_idle: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
		!(state == idle_code && beat.valid))
	else begin
		$error("data beat while the framer is idle");
		fail_count++;
	end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int reset_cycles = 16
) (
	output logic gmii_rx_clk,
	output logic arst_n
);

	// Free running 10 ns clock
	initial begin
		gmii_rx_clk = 1'b0;
		forever #5 gmii_rx_clk = ~gmii_rx_clk;
	end

	// Reset goes away just after an edge and clear of the sampling point
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge gmii_rx_clk);
		#1 arst_n = 1'b1;
	end

endmodule

/* logic/eth_rx_top.sv */
`timescale 1ns/100ps

module eth_rx_top #(
	parameter int NUM_SLOTS  = 4,
	parameter int SLOT_WORDS = 64
) (
	input  logic                gmii_rx_clk,
	input  logic                arst_n,
	input  logic                gmii_rx_dv,
	input  logic                gmii_rx_er,
	input  logic [7:0]          gmii_rxd,
	input  eth_rx_pkg::wb_req_t wb_req,
	output eth_rx_pkg::wb_rsp_t wb_rsp
);

	// Framer output stream
	eth_rx_pkg::rx_beat_t          rx_beat;
	eth_rx_pkg::rx_event_t         rx_event;

	// Per slot wiring
	eth_rx_pkg::rx_beat_t          slot_beat [NUM_SLOTS];
	eth_rx_pkg::rx_event_t         slot_event [NUM_SLOTS];
	eth_rx_pkg::slot_status_t      slot_status [NUM_SLOTS];
	logic [31:0]                   slot_data [NUM_SLOTS];
	logic [NUM_SLOTS-1:0]          slot_release;

	// Host side, index is common to every slot
	logic [$clog2(SLOT_WORDS)-1:0] rd_index;
	logic [15:0]                   drop_count;

	gmii_rx_framer u_framer (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.gmii_rx_dv  (gmii_rx_dv),
		.gmii_rx_er  (gmii_rx_er),
		.gmii_rxd    (gmii_rxd),
		.beat        (rx_beat),
		.event_o     (rx_event)
	);

	rx_slot_dispatch #(
		.NUM_SLOTS (NUM_SLOTS)
	) u_dispatch (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.beat        (rx_beat),
		.event_i     (rx_event),
		.status      (slot_status),
		.slot_beat   (slot_beat),
		.slot_event  (slot_event),
		.drop_count  (drop_count)
	);

	// Identical frame stores
	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		rx_frame_slot #(
			.SLOT_WORDS (SLOT_WORDS)
		) u_slot (
			.gmii_rx_clk (gmii_rx_clk),
			.arst_n      (arst_n),
			.beat        (slot_beat[i]),
			.event_i     (slot_event[i]),
			.release_i   (slot_release[i]),
			.rd_index    (rd_index),
			.rd_data     (slot_data[i]),
			.status      (slot_status[i])
		);
	end

	wb_rx_reader #(
		.NUM_SLOTS  (NUM_SLOTS),
		.SLOT_WORDS (SLOT_WORDS)
	) u_reader (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.status      (slot_status),
		.rd_data     (slot_data),
		.drop_count  (drop_count),
		.rd_index    (rd_index),
		.release_o   (slot_release)
	);

endmodule

/* logic/wb_rx_reader.sv */
`timescale 1ns/100ps

module wb_rx_reader #(
	parameter int NUM_SLOTS  = 4,
	parameter int SLOT_WORDS = 64
) (
	input  logic                          gmii_rx_clk,
	input  logic                          arst_n,
	input  eth_rx_pkg::wb_req_t           wb_req,
	output eth_rx_pkg::wb_rsp_t           wb_rsp,
	input  eth_rx_pkg::slot_status_t      status [NUM_SLOTS],
	input  logic [31:0]                   rd_data [NUM_SLOTS],
	input  logic [15:0]                   drop_count,
	output logic [$clog2(SLOT_WORDS)-1:0] rd_index,
	output logic [NUM_SLOTS-1:0]          release_o
);

	localparam int idx_w  = $clog2(SLOT_WORDS);
	localparam int slot_w = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

	logic [1:0]        kind;
	logic [slot_w-1:0] adr_slot;
	// Slot whose data words are read, picked by the last status access
	logic [slot_w-1:0] sel_slot;
	logic              slot_ok;
	logic              req_new;
	logic              ack_q;
	logic [31:0]       rd_word;
	logic [31:0]       dat_q;

	//////////////////////////////
	// Address decode

	assign kind     = wb_req.adr[7:6];
	assign adr_slot = wb_req.adr[slot_w-1:0];
	assign slot_ok  = int'(adr_slot) < NUM_SLOTS;
	assign rd_index = wb_req.adr[idx_w-1:0];

	// New request, not yet acknowledged
	assign req_new = wb_req.cyc && wb_req.stb && !ack_q;

	always_comb begin
		rd_word = '0;
		case (kind)
			eth_rx_pkg::wb_kind_data:   rd_word = rd_data[sel_slot];
			eth_rx_pkg::wb_kind_status: begin
				if (slot_ok)
					rd_word = {19'd0, status[adr_slot]};
			end
			eth_rx_pkg::wb_kind_drops:  rd_word = {16'd0, drop_count};
			default:                    rd_word = '0;
		endcase
	end

	//////////////////////////////
	// Handshake and release

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q     <= 1'b0;
			sel_slot  <= '0;
			release_o <= '0;
		end else begin
			// Single cycle ack, one cycle after the request shows up
			ack_q     <= req_new;
			release_o <= '0;
			if (req_new && kind == eth_rx_pkg::wb_kind_status && slot_ok) begin
				sel_slot <= adr_slot;
				// Releasing an empty slot does nothing
				if (wb_req.we && status[adr_slot].full)
					release_o[adr_slot] <= 1'b1;
			end
		end
	end

	// Read data captured together with ack
	always_ff @(posedge gmii_rx_clk) begin
		if (req_new)
			dat_q <= rd_word;
	end

	assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

/* logic/rx_frame_slot.sv */
`timescale 1ns/100ps

module rx_frame_slot #(
	parameter int SLOT_WORDS = 64
) (
	input  logic                          gmii_rx_clk,
	input  logic                          arst_n,
	input  eth_rx_pkg::rx_beat_t          beat,
	input  eth_rx_pkg::rx_event_t         event_i,
	input  logic                          release_i,
	input  logic [$clog2(SLOT_WORDS)-1:0] rd_index,
	output logic [31:0]                   rd_data,
	output eth_rx_pkg::slot_status_t      status
);

	localparam int idx_w = $clog2(SLOT_WORDS);

	typedef enum logic [1:0] {
		sl_free,
		sl_fill,
		sl_full
	} slot_state_t;

	slot_state_t state;

	// One extra bit so a completely filled store is visible
	logic [idx_w:0]  wr_ptr;
	logic [10:0]     len_bytes;
	logic            overflow;
	logic            room;
	logic            wr_en;

	logic [31:0]     mem [SLOT_WORDS];

	assign room  = wr_ptr < (idx_w + 1)'(SLOT_WORDS);
	assign wr_en = (state == sl_fill) && beat.valid && room;

	//////////////////////////////
	// Slot control

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= sl_free;
			wr_ptr    <= '0;
			len_bytes <= '0;
			overflow  <= 1'b0;
		end else begin
			case (state)
				sl_free: begin
					if (event_i.start) begin
						state     <= sl_fill;
						wr_ptr    <= '0;
						len_bytes <= '0;
						overflow  <= 1'b0;
					end
				end

				sl_fill: begin
					if (event_i.drop) begin
						// Bad frame, hand the slot straight back
						state     <= sl_free;
						wr_ptr    <= '0;
						len_bytes <= '0;
					end else if (event_i.commit) begin
						// Too long to keep, overflow stays up as a hint
						state <= overflow ? sl_free : sl_full;
					end else if (beat.valid) begin
						if (room) begin
							wr_ptr    <= wr_ptr + 1'b1;
							len_bytes <= len_bytes + {8'd0, beat.bytes};
						end else begin
							overflow <= 1'b1;
						end
					end
				end

				// Hold the frame until the host is done with it
				sl_full: begin
					if (release_i) begin
						state     <= sl_free;
						wr_ptr    <= '0;
						len_bytes <= '0;
					end
				end

				default: state <= sl_free;
			endcase
		end
	end

	//////////////////////////////
	// Word store

	always_ff @(posedge gmii_rx_clk) begin
		if (wr_en)
			mem[wr_ptr[idx_w-1:0]] <= beat.data;
	end

	// Asynchronous read, the reader registers it
	assign rd_data = mem[rd_index];

	assign status = '{full: (state == sl_full), overflow: overflow, len_bytes: len_bytes};

endmodule

/* logic/rx_slot_dispatch.sv */
`timescale 1ns/100ps

module rx_slot_dispatch #(
	parameter int NUM_SLOTS = 4
) (
	input  logic                     gmii_rx_clk,
	input  logic                     arst_n,
	input  eth_rx_pkg::rx_beat_t     beat,
	input  eth_rx_pkg::rx_event_t    event_i,
	input  eth_rx_pkg::slot_status_t status [NUM_SLOTS],
	output eth_rx_pkg::rx_beat_t     slot_beat [NUM_SLOTS],
	output eth_rx_pkg::rx_event_t    slot_event [NUM_SLOTS],
	output logic [15:0]              drop_count
);

	localparam int slot_w = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

	logic [slot_w-1:0] pick;
	logic [slot_w-1:0] cur_slot;
	logic              any_free;
	// Frame in flight owns cur_slot
	logic              active;
	// Frame in flight had nowhere to go
	logic              lost;

	// Lowest numbered free slot, scanned from the top so low wins
	always_comb begin
		pick     = '0;
		any_free = 1'b0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
			if (!status[i].full) begin
				pick     = slot_w'(i);
				any_free = 1'b1;
			end
		end
	end

	// start goes straight to the picked slot, the rest follow cur_slot
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			slot_beat[i]         = beat;
			slot_beat[i].valid   = beat.valid && active && cur_slot == slot_w'(i);
			slot_event[i].start  = event_i.start && any_free && pick == slot_w'(i);
			slot_event[i].commit = event_i.commit && active && cur_slot == slot_w'(i);
			slot_event[i].drop   = event_i.drop && active && cur_slot == slot_w'(i);
		end
	end

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			cur_slot   <= '0;
			active     <= 1'b0;
			lost       <= 1'b0;
			drop_count <= '0;
		end else begin
			if (event_i.start) begin
				active <= any_free;
				lost   <= !any_free;
				if (any_free)
					cur_slot <= pick;
			end else if (event_i.commit || event_i.drop) begin
				active <= 1'b0;
				lost   <= 1'b0;
				// Counted once the frame has actually ended
				if (lost)
					drop_count <= drop_count + 16'd1;
			end
		end
	end

endmodule

/* logic/gmii_rx_framer.sv */
`timescale 1ns/100ps

module gmii_rx_framer (
	input  logic                  gmii_rx_clk,
	input  logic                  arst_n,
	input  logic                  gmii_rx_dv,
	input  logic                  gmii_rx_er,
	input  logic [7:0]            gmii_rxd,
	output eth_rx_pkg::rx_beat_t  beat,
	output eth_rx_pkg::rx_event_t event_o
);

	typedef enum logic [2:0] {
		st_idle,
		st_preamble,
		st_data,
		st_check,
		st_discard
	} state_t;

	state_t state;

	// Byte position inside the word being packed
	logic [1:0]  byte_pos;
	// A complete word is held back, it may still turn out to be FCS
	logic        word_held;
	// er seen after the SFD
	logic        frame_err;
	// At least one beat went out for this frame
	logic        has_data;

	// Last four bytes on the line, oldest in the top bits
	logic [31:0] shift_q;
	logic [31:0] shift_next;
	logic [31:0] held_word;
	logic [31:0] partial_word;

	logic        crc_clear;
	logic        crc_update;
	logic [31:0] crc_calc;
	// CRC as it stood before each of the last four bytes
	logic [31:0] crc_hist [4];

	//////////////////////////////
	// FCS calculation

	// Restart during the preamble, so it is fresh at the first data byte
	assign crc_clear  = (state == st_preamble);
	assign crc_update = (state == st_data) && gmii_rx_dv;

	crc32_eth u_crc (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.clear       (crc_clear),
		.update      (crc_update),
		.din         (gmii_rxd),
		.crc         (crc_calc)
	);

	assign shift_next = {shift_q[23:0], gmii_rxd};

	// Keep only the leading byte_pos bytes of the held word
	assign partial_word = held_word & ~(32'hffff_ffff >> {byte_pos, 3'b000});

	// Data path, shifts only on frame bytes
	always_ff @(posedge gmii_rx_clk) begin
		if (crc_update) begin
			shift_q <= shift_next;
			if (byte_pos == 2'd3)
				held_word <= shift_next;
			// After the last byte, entry 3 covers everything but the FCS
			crc_hist[0] <= crc_calc;
			for (int i = 1; i < 4; i++)
				crc_hist[i] <= crc_hist[i-1];
		end
	end

	//////////////////////////////
	// Receive FSM

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= st_idle;
			byte_pos  <= '0;
			word_held <= 1'b0;
			frame_err <= 1'b0;
			has_data  <= 1'b0;
			beat      <= '0;
			event_o   <= '0;
		end else begin
			// Beats and events are single-cycle pulses
			beat.valid <= 1'b0;
			event_o    <= '0;

			case (state)
				st_idle: begin
					// er outside a frame is ignored, a bad first byte is not
					if (gmii_rx_dv) begin
						if (!gmii_rx_er && gmii_rxd == eth_rx_pkg::preamble_byte)
							state <= st_preamble;
						else
							state <= st_discard;
					end
				end

				st_preamble: begin
					// Runt ending before the SFD, nobody was told so nothing to say
					if (!gmii_rx_dv) begin
						state <= st_idle;
					end else if (gmii_rx_er) begin
						state <= st_discard;
					end else if (gmii_rxd == eth_rx_pkg::sfd_byte) begin
						state         <= st_data;
						event_o.start <= 1'b1;
						byte_pos      <= '0;
						word_held     <= 1'b0;
						frame_err     <= 1'b0;
						has_data      <= 1'b0;
					end else if (gmii_rxd != eth_rx_pkg::preamble_byte) begin
						state <= st_discard;
					end
				end

				st_data: begin
					if (!gmii_rx_dv) begin
						state <= st_check;
						// Tail bytes sit in the held word, the rest of it is FCS
						if (word_held && byte_pos != 2'd0) begin
							beat.valid <= 1'b1;
							beat.data  <= partial_word;
							beat.bytes <= {1'b0, byte_pos};
							has_data   <= 1'b1;
						end
					end else begin
						byte_pos <= byte_pos + 2'd1;
						if (gmii_rx_er)
							frame_err <= 1'b1;
						// Word complete, release the one before it
						if (byte_pos == 2'd3) begin
							word_held <= 1'b1;
							if (word_held) begin
								beat.valid <= 1'b1;
								beat.data  <= held_word;
								beat.bytes <= 3'd4;
								has_data   <= 1'b1;
							end
						end
					end
				end

				st_check: begin
					state <= st_idle;
					// Received FCS is in the shift register in wire order
					if (!frame_err && has_data && crc_hist[3] == shift_q)
						event_o.commit <= 1'b1;
					else
						event_o.drop <= 1'b1;
				end

				// Junk before the SFD, wait out the carrier
				st_discard: begin
					if (!gmii_rx_dv)
						state <= st_idle;
				end

				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* logic/crc32_eth.sv */
`timescale 1ns/100ps

module crc32_eth (
	input  logic        gmii_rx_clk,
	input  logic        arst_n,
	input  logic        clear,
	input  logic        update,
	input  logic [7:0]  din,
	output logic [31:0] crc
);

	// Reflected form of the 802.3 polynomial
	localparam logic [31:0] poly = 32'hedb88320;

	logic [31:0] crc_q;
	logic [31:0] crc_next;

	// One byte per cycle, LSB first as it goes over the wire
	always_comb begin
		crc_next = crc_q;
		for (int i = 0; i < 8; i++) begin
			if (crc_next[0] ^ din[i])
				crc_next = (crc_next >> 1) ^ poly;
			else
				crc_next = crc_next >> 1;
		end
	end

	// Clear wins over update
	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n)
			crc_q <= '1;
		else if (clear)
			crc_q <= '1;
		else if (update)
			crc_q <= crc_next;
	end

	// Inverted remainder, low byte goes out first
	// so reorder to put the first FCS octet in the top bits
	assign crc = ~{crc_q[7:0], crc_q[15:8], crc_q[23:16], crc_q[31:24]};

endmodule

/* logic/eth_rx_pkg.sv */
package eth_rx_pkg;

	//////////////////////////////
	// GMII framing

	// Preamble octet, repeated until the SFD
	localparam logic [7:0] preamble_byte = 8'h55;

	// Start of frame delimiter
	localparam logic [7:0] sfd_byte = 8'hd5;

	//////////////////////////////
	// Wishbone register map

	// Access kind sits in adr[7:6]
	// Slot number sits in the low address bits for a status access
	// Data word index sits in the low address bits for a data access
	localparam logic [1:0] wb_kind_data   = 2'd0;
	localparam logic [1:0] wb_kind_status = 2'd1;
	localparam logic [1:0] wb_kind_drops  = 2'd2;

	//////////////////////////////
	// Shared bundles

	// One packed word of frame data, first byte in data[31:24]
	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic [2:0]  bytes;
	} rx_beat_t;

	// Frame boundary markers, one cycle each
	typedef struct packed {
		logic start;
		logic commit;
		logic drop;
	} rx_event_t;

	// State of one frame slot as seen by the host
	typedef struct packed {
		logic        full;
		logic        overflow;
		logic [10:0] len_bytes;
	} slot_status_t;

	// Wishbone classic master request
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [7:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	// Wishbone classic slave response
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage
